/* include/cache_consts.svh */
// --------------------------------------------------
// Cache request front end constants
// Widths, requestor count, FIFO sizing, setup
// length and the memory command encodings
// --------------------------------------------------
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Requestor side
`define NUM_REQUESTORS 4
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define STRB_WIDTH 4

// Command field and its codes
`define CMD_WIDTH 3
`define CMD_INVALID 3'd0
`define CMD_MEM_READ 3'd1
`define CMD_MEM_WRITE 3'd2
`define CMD_MEM_RESPONSE 3'd3
`define CMD_ENGINE 3'd4

// Request FIFO sizing
`define FIFO_DEPTH 16
`define FIFO_PROG_THRESH 12
`define FIFO_SETUP_CYCLES 8

`endif

/* hdl/cache_pkg.sv */
// --------------------------------------------------
// Cache request front end types
// Vector typedefs for the request fields and the
// state encoding of the control FSM
// --------------------------------------------------
`include "cache_consts.svh"

package cache_pkg;

  // --------------------------------------------------
  // Request fields
  // --------------------------------------------------

  // Byte address, base and offset alike
  typedef logic [`ADDR_WIDTH-1:0] mem_addr_t;

  // One data word, only word 0 travels
  typedef logic [`DATA_WIDTH-1:0] mem_data_t;

  // Memory command code
  typedef logic [`CMD_WIDTH-1:0] mem_cmd_t;

  // Byte write strobes toward the cache
  typedef logic [`STRB_WIDTH-1:0] cache_strb_t;

  // --------------------------------------------------
  // Requestor bookkeeping
  // --------------------------------------------------

  // One bit per requestor
  typedef logic [`NUM_REQUESTORS-1:0] requestor_mask_t;

  // Winner index
  typedef logic [$clog2(`NUM_REQUESTORS)-1:0] requestor_id_t;

  // Packed FIFO word, laid out as id, cmd, addr, wdata, wstrb from the top
  typedef logic [$bits(requestor_id_t) + $bits(mem_cmd_t) + $bits(mem_addr_t)
                 + $bits(mem_data_t) + $bits(cache_strb_t) - 1:0] req_word_t;

  // Control FSM
  typedef enum logic [0:0] {
    CTRL_SETUP,
    CTRL_RUN
  } control_state_e;

endpackage : cache_pkg

/* hdl/request_arbiter.sv */
// --------------------------------------------------
// Round-robin request arbiter
// Grants one valid requestor per cycle and
// registers the winner with address = base+offset
// --------------------------------------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module request_arbiter import cache_pkg::*; (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                grant_enable,
  input  requestor_mask_t                     req_valid,
  input  mem_cmd_t  [`NUM_REQUESTORS-1:0]     req_cmd,
  input  mem_addr_t [`NUM_REQUESTORS-1:0]     req_base,
  input  mem_addr_t [`NUM_REQUESTORS-1:0]     req_offset,
  input  mem_data_t [`NUM_REQUESTORS-1:0]     req_data,
  output requestor_mask_t                     req_grant,
  output logic                                arb_valid,
  output requestor_id_t                       arb_id,
  output mem_cmd_t                            arb_cmd,
  output mem_addr_t                           arb_addr,
  output mem_data_t                           arb_data
);

  // Winner of the previous grant, search starts just after it
  requestor_id_t last_winner;

  // Candidate found this cycle
  logic          pick_found;
  requestor_id_t pick_id;
  logic          grant_fire;

  // --------------------------------------------------
  // Winner search
  // --------------------------------------------------
  always_comb begin
    pick_found = 1'b0;
    pick_id    = last_winner;
    // Walk the ring once, last winner comes last
    for (int i = 1; i <= `NUM_REQUESTORS; i++) begin
      if (!pick_found &&
          req_valid[(int'(last_winner) + i) % `NUM_REQUESTORS]) begin
        pick_found = 1'b1;
        pick_id    = requestor_id_t'((int'(last_winner) + i) % `NUM_REQUESTORS);
      end
    end
  end

  // No grant while the control side holds us off
  assign grant_fire = pick_found & grant_enable;

  // One-hot grant, same cycle as the request
  always_comb begin
    req_grant = '0;
    if (grant_fire) begin
      req_grant[pick_id] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Pointer and output stage
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      // Requestor 0 wins first
      last_winner <= requestor_id_t'(`NUM_REQUESTORS - 1);
      arb_valid   <= 1'b0;
    end else begin
      arb_valid <= grant_fire;
      if (grant_fire) begin
        last_winner <= pick_id;
      end
    end
  end

  // Winner payload, address add folded into this stage
  always_ff @(posedge ap_clk) begin
    arb_id   <= pick_id;
    arb_cmd  <= req_cmd[pick_id];
    arb_addr <= req_base[pick_id] + req_offset[pick_id];
    arb_data <= req_data[pick_id];
  end

endmodule : request_arbiter

/* hdl/cache_request_translate.sv */
// --------------------------------------------------
// Memory packet to cache request translation
// Derives write strobes, drops non-memory commands
// and registers the packed FIFO word
// --------------------------------------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_request_translate import cache_pkg::*; (
  input  logic          ap_clk,
  input  logic          areset_control,
  input  logic          arb_valid,
  input  requestor_id_t arb_id,
  input  mem_cmd_t      arb_cmd,
  input  mem_addr_t     arb_addr,
  input  mem_data_t     arb_data,
  output logic          fifo_wr_en,
  output req_word_t     fifo_wr_data
);

  // Strobes for this command
  cache_strb_t req_strb;

  // Command is real memory traffic
  logic        keep_cmd;

  // Word before the register
  req_word_t   req_word;

  // --------------------------------------------------
  // Strobe decode
  // --------------------------------------------------
  always_comb begin
    case (arb_cmd)
      `CMD_MEM_WRITE: begin
        // Full word write
        req_strb = '1;
      end
      default: begin
        req_strb = '0;
      end
    endcase
  end

  // --------------------------------------------------
  // Command filter
  // --------------------------------------------------

  // Response, invalid and engine never reach the cache
  assign keep_cmd = (arb_cmd != `CMD_MEM_RESPONSE) &&
                    (arb_cmd != `CMD_INVALID) &&
                    (arb_cmd != `CMD_ENGINE);

  // Field order matches the unpack at the top level
  assign req_word = {arb_id, arb_cmd, arb_addr, arb_data, req_strb};

  // --------------------------------------------------
  // Register stage
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_wr_en <= 1'b0;
    end else begin
      fifo_wr_en <= arb_valid & keep_cmd;
    end
  end

  // Payload only
  always_ff @(posedge ap_clk) begin
    fifo_wr_data <= req_word;
  end

endmodule : cache_request_translate

/* hdl/request_fifo.sv */
// --------------------------------------------------
// Synchronous request FIFO
// Circular buffer with occupancy count, registered
// read port and full, empty, prog_full flags
// --------------------------------------------------
`timescale 1ns/100ps

module request_fifo import cache_pkg::*; #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic      ap_clk,
  input  logic      areset_control,
  input  logic      wr_en,
  input  req_word_t wr_data,
  input  logic      rd_en,
  output logic      rd_valid,
  output req_word_t rd_data,
  output logic      full,
  output logic      empty,
  output logic      prog_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage
  req_word_t mem [DEPTH];

  // Pointers and occupancy
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Accepted operations
  logic do_write;
  logic do_read;

  // --------------------------------------------------
  // Flags
  // --------------------------------------------------
  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);
  assign prog_full = (count >= CNT_W'(PROG_THRESH));

  // Overflow and underflow are ignored
  assign do_write = wr_en & ~full;
  assign do_read  = rd_en & ~empty;

  // --------------------------------------------------
  // Pointers and count
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // Storage and read port
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Valid trails the pop by one cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_read;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (do_read) begin
      rd_data <= mem[rd_ptr];
    end
  end

endmodule : request_fifo

/* hdl/cache_request_control.sv */
// --------------------------------------------------
// Cache request control FSM
// Holds off traffic during FIFO setup, throttles
// grants near full and gates FIFO pops
// --------------------------------------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_request_control import cache_pkg::*; (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic empty,
  input  logic prog_full,
  input  logic out_ready,
  output logic setup_busy,
  output logic grant_enable,
  output logic rd_en
);

  localparam int SETUP_W = $clog2(`FIFO_SETUP_CYCLES + 1);

  control_state_e state;

  // Cycles spent in setup so far
  logic [SETUP_W-1:0] setup_count;

  logic in_run;

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state       <= CTRL_SETUP;
      setup_count <= '0;
    end else begin
      case (state)
        CTRL_SETUP: begin
          setup_count <= setup_count + 1'b1;
          // Last setup cycle
          if (setup_count == SETUP_W'(`FIFO_SETUP_CYCLES - 1)) begin
            state <= CTRL_RUN;
          end
        end
        CTRL_RUN: begin
          // Stays here until the next reset
          state <= CTRL_RUN;
        end
        default: begin
          state <= CTRL_SETUP;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign in_run     = (state == CTRL_RUN);
  assign setup_busy = (state == CTRL_SETUP);

  // Threshold leaves room for the requests in flight
  assign grant_enable = in_run & ~prog_full;

  // Pop only with data and a ready consumer
  assign rd_en = in_run & out_ready & ~empty;

endmodule : cache_request_control

/* hdl/cache_generator_request.sv */
// --------------------------------------------------
// Cache request generator top level
// Arbitrates requestors, translates the winner to
// a cache request and queues it for the consumer
// --------------------------------------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_generator_request import cache_pkg::*; (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  requestor_mask_t                 req_valid,
  input  mem_cmd_t  [`NUM_REQUESTORS-1:0] req_cmd,
  input  mem_addr_t [`NUM_REQUESTORS-1:0] req_base,
  input  mem_addr_t [`NUM_REQUESTORS-1:0] req_offset,
  input  mem_data_t [`NUM_REQUESTORS-1:0] req_data,
  input  logic                            out_ready,
  output requestor_mask_t                 req_grant,
  output logic                            out_valid,
  output mem_addr_t                       out_addr,
  output mem_data_t                       out_wdata,
  output cache_strb_t                     out_wstrb,
  output mem_cmd_t                        out_cmd,
  output requestor_id_t                   out_id,
  output logic                            setup_busy
);

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  // Control
  logic grant_enable;
  logic rd_en;

  // Arbiter stage
  logic          arb_valid;
  requestor_id_t arb_id;
  mem_cmd_t      arb_cmd;
  mem_addr_t     arb_addr;
  mem_data_t     arb_data;

  // FIFO
  logic      fifo_wr_en;
  req_word_t fifo_wr_data;
  req_word_t fifo_rd_data;
  logic      fifo_empty;
  logic      fifo_prog_full;

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  cache_request_control u_control (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .empty         (fifo_empty),
    .prog_full     (fifo_prog_full),
    .out_ready     (out_ready),
    .setup_busy    (setup_busy),
    .grant_enable  (grant_enable),
    .rd_en         (rd_en)
  );

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  request_arbiter u_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .grant_enable  (grant_enable),
    .req_valid     (req_valid),
    .req_cmd       (req_cmd),
    .req_base      (req_base),
    .req_offset    (req_offset),
    .req_data      (req_data),
    .req_grant     (req_grant),
    .arb_valid     (arb_valid),
    .arb_id        (arb_id),
    .arb_cmd       (arb_cmd),
    .arb_addr      (arb_addr),
    .arb_data      (arb_data)
  );

  cache_request_translate u_translate (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .arb_valid     (arb_valid),
    .arb_id        (arb_id),
    .arb_cmd       (arb_cmd),
    .arb_addr      (arb_addr),
    .arb_data      (arb_data),
    .fifo_wr_en    (fifo_wr_en),
    .fifo_wr_data  (fifo_wr_data)
  );

  // Read stage is the consumer output register
  request_fifo #(
    .DEPTH      (`FIFO_DEPTH),
    .PROG_THRESH(`FIFO_PROG_THRESH)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (fifo_wr_en),
    .wr_data       (fifo_wr_data),
    .rd_en         (rd_en),
    .rd_valid      (out_valid),
    .rd_data       (fifo_rd_data),
    .full          (),
    .empty         (fifo_empty),
    .prog_full     (fifo_prog_full)
  );

  // Unpack in the order the translate stage packed it
  assign {out_id, out_cmd, out_addr, out_wdata, out_wstrb} = fifo_rd_data;

endmodule : cache_generator_request

/* test/tb_clock_gen.sv */
// --------------------------------------------------
// Testbench clock and reset source
// 10 ns ap_clk, areset_control high for 8 cycles
// --------------------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
  output logic ap_clk,
  output logic areset_control
);

  // Free running clock
  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    areset_control = 1'b1;
    repeat (8) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_control = 1'b0;
  end

endmodule : tb_clock_gen

/* test/tb_cache_generator_request.sv */
// --------------------------------------------------
// Cache request generator testbench
// Directed tests with a reference queue filled on
// each grant, typed compare tasks and a watchdog
// --------------------------------------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module tb_cache_generator_request import cache_pkg::*;;

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 400 + 200;

  logic ap_clk;
  logic areset_control;

  // DUT inputs
  requestor_mask_t                 req_valid;
  mem_cmd_t  [`NUM_REQUESTORS-1:0] req_cmd;
  mem_addr_t [`NUM_REQUESTORS-1:0] req_base;
  mem_addr_t [`NUM_REQUESTORS-1:0] req_offset;
  mem_data_t [`NUM_REQUESTORS-1:0] req_data;
  logic                            out_ready;

  // DUT outputs
  requestor_mask_t req_grant;
  logic            out_valid;
  mem_addr_t       out_addr;
  mem_data_t       out_wdata;
  cache_strb_t     out_wstrb;
  mem_cmd_t        out_cmd;
  requestor_id_t   out_id;
  logic            setup_busy;

  // Reference model state, one entry per queued request
  mem_addr_t     exp_addr_q[$];
  mem_data_t     exp_data_q[$];
  cache_strb_t   exp_strb_q[$];
  mem_cmd_t      exp_cmd_q[$];
  requestor_id_t exp_id_q[$];
  requestor_id_t grant_log[$];

  integer        seed;
  int            error_count;
  string         cur_test;
  requestor_id_t mon_id;
  cache_strb_t   mon_strb;

  tb_clock_gen u_clock_gen (
    .ap_clk        (ap_clk),
    .areset_control(areset_control)
  );

  cache_generator_request DUT (
    .ap_clk(ap_clk), .areset_control(areset_control),
    .req_valid(req_valid), .req_cmd(req_cmd), .req_base(req_base),
    .req_offset(req_offset), .req_data(req_data), .out_ready(out_ready),
    .req_grant(req_grant), .out_valid(out_valid), .out_addr(out_addr),
    .out_wdata(out_wdata), .out_wstrb(out_wstrb), .out_cmd(out_cmd),
    .out_id(out_id), .setup_busy(setup_busy)
  );

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
    if (exp !== act) begin
      error_count++;
      $display("Error [%s] addr expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
    if (exp !== act) begin
      error_count++;
      $display("Error [%s] wdata expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_strb(input string name, input cache_strb_t exp, input cache_strb_t act);
    if (exp !== act) begin
      error_count++;
      $display("Error [%s] wstrb expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_cmd(input string name, input mem_cmd_t exp, input mem_cmd_t act);
    if (exp !== act) begin
      error_count++;
      $display("Error [%s] cmd expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input requestor_id_t exp, input requestor_id_t act);
    if (exp !== act) begin
      error_count++;
      $display("Error [%s] id expected %0d actual %0d", name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // Monitor, sampled on the rising edge
  // --------------------------------------------------
  always @(posedge ap_clk) begin
    if (!areset_control) begin
      if (setup_busy && (req_grant != '0 || out_valid)) begin
        error_count++;
        $display("Error [%s] grant or output seen while setup is still busy", cur_test);
      end
      if (!$onehot0(req_grant)) begin
        error_count++;
        $display("Error [%s] grant is not one-hot: %b", cur_test, req_grant);
      end else if (req_grant != '0) begin
        for (int i = 0; i < `NUM_REQUESTORS; i++) begin
          if (req_grant[i]) mon_id = requestor_id_t'(i);
        end
        grant_log.push_back(mon_id);
        // Only memory reads and writes reach the cache
        if (req_cmd[mon_id] == `CMD_MEM_READ || req_cmd[mon_id] == `CMD_MEM_WRITE) begin
          mon_strb = (req_cmd[mon_id] == `CMD_MEM_WRITE) ? '1 : '0;
          exp_addr_q.push_back(req_base[mon_id] + req_offset[mon_id]);
          exp_data_q.push_back(req_data[mon_id]);
          exp_strb_q.push_back(mon_strb);
          exp_cmd_q.push_back(req_cmd[mon_id]);
          exp_id_q.push_back(mon_id);
        end
      end
      if (out_valid) begin
        if (exp_id_q.size() == 0) begin
          error_count++;
          $display("Error [%s] output appeared with no request pending", cur_test);
        end else begin
          check_addr(cur_test, exp_addr_q.pop_front(), out_addr);
          check_data(cur_test, exp_data_q.pop_front(), out_wdata);
          check_strb(cur_test, exp_strb_q.pop_front(), out_wstrb);
          check_cmd(cur_test, exp_cmd_q.pop_front(), out_cmd);
          check_id(cur_test, exp_id_q.pop_front(), out_id);
        end
      end
    end
  end

  // --------------------------------------------------
  // Stimulus helpers, all called on a falling edge
  // --------------------------------------------------
  task automatic load_slot(input int idx, input mem_cmd_t cmd);
    req_cmd[idx]    = cmd;
    req_base[idx]   = $random(seed);
    req_offset[idx] = $random(seed);
    req_data[idx]   = $random(seed);
    req_valid[idx]  = 1'b1;
  endtask

  // Hold requests until every one has seen its grant
  task automatic drain_requests();
    requestor_mask_t seen;
    while (req_valid != '0) begin
      @(posedge ap_clk);
      seen = req_grant;
      @(negedge ap_clk);
      req_valid = req_valid & ~seen;
    end
  endtask

  task automatic send_one(input int idx, input mem_cmd_t cmd);
    @(negedge ap_clk);
    load_slot(idx, cmd);
    drain_requests();
  endtask

  // Empty reference queue, then a tail to catch strays
  task automatic wait_outputs();
    while (exp_id_q.size() != 0) @(negedge ap_clk);
    repeat (6) @(negedge ap_clk);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset_setup();
    int busy_cycles;
    cur_test    = "reset_setup";
    busy_cycles = 0;
    @(negedge ap_clk);
    // Reset drops on a falling edge
    wait (areset_control == 1'b0);
    // Request held across setup, granted only after it
    load_slot(0, `CMD_MEM_WRITE);
    while (setup_busy) begin
      @(negedge ap_clk);
      busy_cycles++;
    end
    if (busy_cycles != `FIFO_SETUP_CYCLES) begin
      error_count++;
      $display("Error [%s] setup cycles expected %0d actual %0d",
               cur_test, `FIFO_SETUP_CYCLES, busy_cycles);
    end
    drain_requests();
    wait_outputs();
  endtask

  task automatic test_single_write();
    cur_test = "single_write";
    send_one(2, `CMD_MEM_WRITE);
    wait_outputs();
  endtask

  task automatic test_filtered_cmds();
    cur_test = "filtered_cmds";
    send_one(1, `CMD_MEM_READ);
    send_one(3, `CMD_MEM_RESPONSE);
    send_one(3, `CMD_INVALID);
    send_one(3, `CMD_ENGINE);
    // Write behind the dropped ones still passes
    send_one(0, `CMD_MEM_WRITE);
    wait_outputs();
  endtask

  task automatic test_round_robin();
    int            first;
    requestor_id_t prev;
    cur_test = "round_robin";
    first    = grant_log.size();
    prev     = grant_log[first-1];
    @(negedge ap_clk);
    for (int i = 0; i < `NUM_REQUESTORS; i++) begin
      load_slot(i, (i % 2 == 0) ? `CMD_MEM_WRITE : `CMD_MEM_READ);
    end
    drain_requests();
    if (grant_log.size() - first != `NUM_REQUESTORS) begin
      error_count++;
      $display("Error [%s] grant count expected %0d actual %0d",
               cur_test, `NUM_REQUESTORS, grant_log.size() - first);
    end
    // Each winner follows the one before it
    for (int k = first; k < grant_log.size(); k++) begin
      check_id(cur_test, requestor_id_t'((int'(prev) + 1) % `NUM_REQUESTORS), grant_log[k]);
      prev = grant_log[k];
    end
    wait_outputs();
  endtask

  task automatic test_back_pressure();
    int              idle;
    int              accepted;
    requestor_mask_t seen;
    cur_test = "back_pressure";
    idle     = 0;
    accepted = 0;
    @(negedge ap_clk);
    out_ready = 1'b0;
    // Keep every requestor busy until grants dry up
    while (idle < 20) begin
      for (int i = 0; i < `NUM_REQUESTORS; i++) begin
        if (!req_valid[i]) load_slot(i, ($random(seed) & 1) ? `CMD_MEM_WRITE : `CMD_MEM_READ);
      end
      @(posedge ap_clk);
      seen = req_grant;
      @(negedge ap_clk);
      req_valid = req_valid & ~seen;
      if (seen != '0) begin
        accepted++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (accepted > `FIFO_DEPTH) begin
      error_count++;
      $display("Error [%s] accepted at most %0d actual %0d", cur_test, `FIFO_DEPTH, accepted);
    end
    req_valid = '0;
    out_ready = 1'b1;
    wait_outputs();
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    req_valid   = '0;
    req_cmd     = '0;
    req_base    = '0;
    req_offset  = '0;
    req_data    = '0;
    out_ready   = 1'b1;
    seed        = 9824;
    error_count = 0;
    cur_test    = "reset";
    test_reset_setup();
    test_single_write();
    test_filtered_cmds();
    test_round_robin();
    test_back_pressure();
    $display("Tests run: %0d, errors: %0d", NUM_TESTS, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("Timeout in test %s after %0d cycles", cur_test, WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule : tb_cache_generator_request

/* list.f */
+incdir+include
hdl/cache_pkg.sv
hdl/request_arbiter.sv
hdl/cache_request_translate.sv
hdl/request_fifo.sv
hdl/cache_request_control.sv
hdl/cache_generator_request.sv
test/tb_clock_gen.sv
test/tb_cache_generator_request.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cache request generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_cache_generator_request \
  -o tb_sim > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/tb_sim > "$SIM_LOG" 2>&1 \
  || { echo "Build or run failed, see $BUILD_LOG and $SIM_LOG"; exit 1; }

grep -q "^Verification passed$" "$SIM_LOG" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see $SIM_LOG"; exit 1; }
